/* all.f */
+incdir+include
hdl/obi_pkg.sv
hdl/periph_pkg.sv
hdl/periph_bus_bridge.sv
hdl/soc_ctrl.sv
hdl/uart_tx.sv
hdl/intr_ctrl.sv
hdl/peripheral_subsystem.sv
bench/periph_checker.sv
bench/tb_peripheral_subsystem.sv

/* Bender.yml */
package:
  name: peripheral_subsystem

sources:
  - include_dirs:
      - include
    files:
      - hdl/obi_pkg.sv
      - hdl/periph_pkg.sv
      - hdl/periph_bus_bridge.sv
      - hdl/soc_ctrl.sv
      - hdl/uart_tx.sv
      - hdl/intr_ctrl.sv
      - hdl/peripheral_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/periph_checker.sv
      - bench/tb_peripheral_subsystem.sv

/* bench/tb_peripheral_subsystem.sv */
/*
 * Testbench top: clock, reset, random bus traffic, external register
 * memory and cycle limit around the peripheral subsystem
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module tb_peripheral_subsystem;

  localparam int NUM_OPS     = 400;
  localparam int MAX_FRAMES  = 12;
  localparam int MAX_DIV     = 8;
  localparam int CYCLE_LIMIT = 20 * NUM_OPS + MAX_FRAMES * 10 * MAX_DIV;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic                  we;
  obi_pkg::obi_addr_t    addr;
  obi_pkg::obi_data_t    wdata;
  logic                  gnt;
  logic                  rvalid;
  obi_pkg::obi_data_t    rdata;
  logic                  err;
  logic                  exit_valid;
  periph_pkg::reg_data_t exit_value;
  logic                  uart_tx;
  logic                  uart_tx_en;
  logic [`EXT_NINTR-1:0] intr_ext;
  logic                  irq;
  logic                  msip;
  logic                  ext_valid;
  logic                  ext_we;
  periph_pkg::reg_addr_t ext_addr;
  periph_pkg::reg_data_t ext_wdata;
  periph_pkg::reg_data_t ext_rdata;
  periph_pkg::reg_data_t ext_mem [1024];
  int                    cycles = 0;
  int                    frames = 0;
  int                    err_cnt;
  int                    chk_cnt;

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .err_o        (err),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value),
    .uart_tx_o    (uart_tx),
    .uart_tx_en_o (uart_tx_en),
    .intr_ext_i   (intr_ext),
    .irq_o        (irq),
    .msip_o       (msip),
    .ext_valid_o  (ext_valid),
    .ext_we_o     (ext_we),
    .ext_addr_o   (ext_addr),
    .ext_wdata_o  (ext_wdata),
    .ext_rdata_i  (ext_rdata)
  );

  periph_checker periph_checker_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .gnt_i        (gnt),
    .rvalid_i     (rvalid),
    .rdata_i      (rdata),
    .err_i        (err),
    .exit_valid_i (exit_valid),
    .exit_value_i (exit_value),
    .uart_tx_i    (uart_tx),
    .uart_tx_en_i (uart_tx_en),
    .intr_ext_i   (intr_ext),
    .irq_i        (irq),
    .msip_i       (msip),
    .ext_valid_i  (ext_valid),
    .ext_we_i     (ext_we),
    .ext_addr_i   (ext_addr),
    .ext_wdata_i  (ext_wdata),
    .ext_rdata_i  (ext_rdata),
    .err_cnt_o    (err_cnt),
    .chk_cnt_o    (chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // External register slave answers in the strobe cycle
  assign ext_rdata = ext_mem[ext_addr[11:2]];

  always @(posedge clk) begin
    if (ext_valid && ext_we) ext_mem[ext_addr[11:2]] <= ext_wdata;
  end

  function automatic obi_pkg::obi_addr_t win_addr(input logic [3:0] win, input logic [11:0] ofs);
    return {16'h0, win, ofs};
  endfunction

  task automatic bus_access(input logic wr, input obi_pkg::obi_addr_t a,
                            input obi_pkg::obi_data_t d, output obi_pkg::obi_data_t r);
    @(posedge clk);
    #2;
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    @(posedge clk);
    #2;
    req = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    r = rdata;
  endtask

  task automatic write_reg(input obi_pkg::obi_addr_t a, input obi_pkg::obi_data_t d);
    obi_pkg::obi_data_t ignored;
    bus_access(1'b1, a, d, ignored);
  endtask

  task automatic read_reg(input obi_pkg::obi_addr_t a, output obi_pkg::obi_data_t r);
    bus_access(1'b0, a, '0, r);
  endtask

  task automatic wait_uart_idle();
    obi_pkg::obi_data_t st;
    st = 32'h1;
    while (st[0]) read_reg(win_addr(`UART_WIN, `UART_STATUS_OFS), st);
  endtask

  task automatic random_op();
    obi_pkg::obi_data_t r;
    obi_pkg::obi_data_t d;
    obi_pkg::obi_addr_t a;
    int                 kind;
    kind = $urandom_range(0, 9);
    d    = $urandom;
    if ($urandom_range(0, 7) == 0) begin
      @(posedge clk);
      #2;
      intr_ext = $urandom;
    end
    case (kind)
      0: write_reg(win_addr(`SOC_CTRL_WIN, 12'(4 * $urandom_range(0, 3))), d);
      1: read_reg(win_addr(`SOC_CTRL_WIN, 12'(4 * $urandom_range(0, 3))), r);
      2: write_reg(win_addr(`UART_WIN, `UART_DIV_OFS), $urandom_range(0, MAX_DIV));
      3: begin
        if (frames < MAX_FRAMES) begin
          wait_uart_idle();
          write_reg(win_addr(`UART_WIN, `UART_TXDATA_OFS), {24'h0, d[7:0]});
          frames++;
        end else begin
          read_reg(win_addr(`UART_WIN, `UART_STATUS_OFS), r);
        end
      end
      4: begin
        if (d[8]) write_reg(win_addr(`UART_WIN, `UART_STATUS_OFS), d & 32'h2);
        else read_reg(win_addr(`UART_WIN, 12'(4 * $urandom_range(0, 3))), r);
      end
      5: write_reg(win_addr(`INTR_WIN, 12'(4 * $urandom_range(0, 3))), d);
      6: read_reg(win_addr(`INTR_WIN, 12'(4 * $urandom_range(0, 3))), r);
      7: write_reg(win_addr(`EXT_WIN, 12'(4 * $urandom_range(0, 15))), d);
      8: read_reg(win_addr(`EXT_WIN, 12'(4 * $urandom_range(0, 15))), r);
      default: begin
        // Upper bits set, or a window number of 4 and above
        a = $urandom;
        if (d[1]) a[31:16] = 16'h0;
        a[14] = 1'b1;
        if (d[0]) write_reg(a, d);
        else read_reg(a, r);
      end
    endcase
  endtask

  initial begin
    obi_pkg::obi_data_t r;
    void'($urandom(98599));
    rst_n    = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    intr_ext = '0;
    for (int i = 0; i < 1024; i++) ext_mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_9E37);
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    read_reg(win_addr(`SOC_CTRL_WIN, `SOC_SCRATCH_OFS), r);
    read_reg(win_addr(`UART_WIN, `UART_DIV_OFS), r);
    read_reg(win_addr(`INTR_WIN, `INTR_PENDING_OFS), r);
    repeat (NUM_OPS) random_op();
    wait_uart_idle();
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_peripheral_subsystem

/* bench/periph_checker.sv */
/*
 * Subsystem checker: register, interrupt and UART model compared with the
 * bus responses, the serial line and the control outputs of the DUT
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_checker (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  obi_pkg::obi_addr_t    addr_i,
  input  obi_pkg::obi_data_t    wdata_i,
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  input  obi_pkg::obi_data_t    rdata_i,
  input  logic                  err_i,
  input  logic                  exit_valid_i,
  input  periph_pkg::reg_data_t exit_value_i,
  input  logic                  uart_tx_i,
  input  logic                  uart_tx_en_i,
  input  logic [`EXT_NINTR-1:0] intr_ext_i,
  input  logic                  irq_i,
  input  logic                  msip_i,
  input  logic                  ext_valid_i,
  input  logic                  ext_we_i,
  input  periph_pkg::reg_addr_t ext_addr_i,
  input  periph_pkg::reg_data_t ext_wdata_i,
  input  periph_pkg::reg_data_t ext_rdata_i,
  output int                    err_cnt_o,
  output int                    chk_cnt_o
);

  // Request in flight with window 4 for unmapped
  logic                  p_valid;
  logic                  p_we;
  int                    p_win;
  periph_pkg::reg_addr_t p_ofs;
  periph_pkg::reg_data_t p_wdata;
  logic                  m_exit_valid;
  periph_pkg::reg_data_t m_exit_value;
  periph_pkg::reg_data_t m_scratch;
  periph_pkg::uart_div_t m_div;
  int                    u_div;
  int                    u_left;
  int                    u_pos;
  logic [7:0]            u_byte;
  logic                  m_done;
  periph_pkg::intr_vec_t m_pend;
  periph_pkg::intr_vec_t m_en;
  periph_pkg::intr_vec_t m_insvc;
  logic                  m_msip;
  periph_pkg::reg_data_t ext_model [1024];
  logic                  ext_known [1024];

  function automatic int window_of(obi_pkg::obi_addr_t a);
    if (a[31:16] != 16'h0 || a[15:12] > `EXT_WIN) return 4;
    return int'(a[15:12]);
  endfunction

  function automatic int lowest_claim();
    for (int i = 1; i < `INTR_NUM_SRC; i++) begin
      if (m_pend[i] && m_en[i]) return i;
    end
    return 0;
  endfunction

  // Start bit, eight data bits LSB first, stop bit
  function automatic logic line_level();
    int b;
    if (u_left == 0) return 1'b1;
    b = u_pos / u_div;
    if (b == 0) return 1'b0;
    if (b == 9) return 1'b1;
    return u_byte[b-1];
  endfunction

  function automatic periph_pkg::reg_data_t read_value();
    periph_pkg::reg_data_t v;
    v = '0;
    case (p_win)
      `SOC_CTRL_WIN: begin
        if (p_ofs == `SOC_EXIT_VALID_OFS) v = {31'd0, m_exit_valid};
        if (p_ofs == `SOC_EXIT_VALUE_OFS) v = m_exit_value;
        if (p_ofs == `SOC_SCRATCH_OFS) v = m_scratch;
      end
      `UART_WIN: begin
        if (p_ofs == `UART_STATUS_OFS) v = {30'd0, m_done, u_left != 0};
        if (p_ofs == `UART_DIV_OFS) v = {16'd0, m_div};
      end
      `INTR_WIN: begin
        if (p_ofs == `INTR_PENDING_OFS) v = {24'd0, m_pend};
        if (p_ofs == `INTR_ENABLE_OFS) v = {24'd0, m_en};
        if (p_ofs == `INTR_CLAIM_OFS) v = lowest_claim();
        if (p_ofs == `INTR_MSIP_OFS) v = {31'd0, m_msip};
      end
      `EXT_WIN: v = ext_known[p_ofs[11:2]] ? ext_model[p_ofs[11:2]] : ext_rdata_i;
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt_o++;
    if (got !== exp) begin
      err_cnt_o++;
      $display("** Error @ %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic reset_model();
    p_valid      = 1'b0;
    m_exit_valid = 1'b0;
    m_exit_value = '0;
    m_scratch    = '0;
    m_div        = `UART_DIV_RESET;
    u_div        = 1;
    u_left       = 0;
    u_pos        = 0;
    m_done       = 1'b0;
    m_pend       = '0;
    m_en         = '0;
    m_insvc      = '0;
    m_msip       = 1'b0;
  endtask

  // State after the coming clock edge
  task automatic update_model();
    periph_pkg::intr_vec_t src;
    int                    id;
    logic                  busy;
    logic                  frame_end;
    src  = {intr_ext_i, m_done, 1'b0};
    id   = lowest_claim();
    busy = (u_left != 0);
    m_pend    = m_pend | (src & ~m_insvc);
    m_pend[0] = 1'b0;
    if (p_valid && !p_we && p_win == `INTR_WIN && p_ofs == `INTR_CLAIM_OFS) begin
      m_pend[id] = 1'b0;
      if (id != 0) m_insvc[id] = 1'b1;
    end
    frame_end = 1'b0;
    if (busy) begin
      u_pos++;
      u_left--;
      frame_end = (u_left == 0);
    end
    if (p_valid && p_we) begin
      case (p_win)
        `SOC_CTRL_WIN: begin
          if (p_ofs == `SOC_EXIT_VALID_OFS) m_exit_valid = p_wdata[0];
          if (p_ofs == `SOC_EXIT_VALUE_OFS) m_exit_value = p_wdata;
          if (p_ofs == `SOC_SCRATCH_OFS) m_scratch = p_wdata;
        end
        `UART_WIN: begin
          if (p_ofs == `UART_DIV_OFS) m_div = p_wdata[15:0];
          if (p_ofs == `UART_STATUS_OFS && p_wdata[1]) m_done = 1'b0;
          if (p_ofs == `UART_TXDATA_OFS && !busy) begin
            u_div  = (m_div == '0) ? 1 : int'(m_div);
            u_left = 10 * u_div;
            u_pos  = 0;
            u_byte = p_wdata[7:0];
          end
        end
        `INTR_WIN: begin
          if (p_ofs == `INTR_ENABLE_OFS) m_en = p_wdata[`INTR_NUM_SRC-1:0];
          if (p_ofs == `INTR_CLAIM_OFS) m_insvc[p_wdata[2:0]] = 1'b0;
          if (p_ofs == `INTR_MSIP_OFS) m_msip = p_wdata[0];
        end
        `EXT_WIN: begin
          ext_model[p_ofs[11:2]] = p_wdata;
          ext_known[p_ofs[11:2]] = 1'b1;
        end
        default: ;
      endcase
    end
    // End of a frame beats a same-cycle clear
    if (frame_end) m_done = 1'b1;
  endtask

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
    for (int i = 0; i < 1024; i++) ext_known[i] = 1'b0;
  end

  // Sampled mid-cycle where inputs and outputs are settled
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      reset_model();
    end else begin
      compare("gnt", gnt_i, req_i);
      compare("rvalid", rvalid_i, p_valid);
      compare("external strobe", ext_valid_i, p_valid && p_win == `EXT_WIN);
      compare("uart_tx_en", uart_tx_en_i, u_left != 0);
      compare("uart_tx", uart_tx_i, line_level());
      compare("irq", irq_i, |(m_pend & m_en));
      compare("msip", msip_i, m_msip);
      compare("exit_valid", exit_valid_i, m_exit_valid);
      compare("exit_value", exit_value_i, m_exit_value);
      if (p_valid) begin
        compare("err", err_i, p_win == 4);
        compare("rdata", rdata_i, p_we ? 32'h0 : read_value());
        if (p_win == `EXT_WIN) begin
          compare("external we", ext_we_i, p_we);
          compare("external addr", ext_addr_i, p_ofs);
          if (p_we) compare("external wdata", ext_wdata_i, p_wdata);
        end
      end
      update_model();
      p_valid = req_i && gnt_i;
      p_we    = we_i;
      p_win   = window_of(addr_i);
      p_ofs   = addr_i[11:0];
      p_wdata = wdata_i;
    end
  end

endmodule : periph_checker

/* hdl/peripheral_subsystem.sv */
/*
 * Peripheral subsystem top: OBI bridge, system control, UART,
 * interrupt controller and an external register port
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module peripheral_subsystem (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   req_i,
  input  logic                   we_i,
  input  obi_pkg::obi_addr_t     addr_i,
  input  obi_pkg::obi_data_t     wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output obi_pkg::obi_data_t     rdata_o,
  output logic                   err_o,

  output logic                   exit_valid_o,
  output periph_pkg::reg_data_t  exit_value_o,
  output logic                   uart_tx_o,
  output logic                   uart_tx_en_o,

  input  logic [`EXT_NINTR-1:0]  intr_ext_i,
  output logic                   irq_o,
  output logic                   msip_o,

  output logic                   ext_valid_o,
  output logic                   ext_we_o,
  output periph_pkg::reg_addr_t  ext_addr_o,
  output periph_pkg::reg_data_t  ext_wdata_o,
  input  periph_pkg::reg_data_t  ext_rdata_i
);

  periph_pkg::reg_addr_t reg_addr;
  logic                  reg_we;
  periph_pkg::reg_data_t reg_wdata;
  logic                  soc_valid;
  logic                  uart_valid;
  logic                  intr_valid;
  periph_pkg::reg_data_t soc_rdata;
  periph_pkg::reg_data_t uart_rdata;
  periph_pkg::reg_data_t intr_rdata;
  logic                  uart_tx_done;
  periph_pkg::intr_vec_t intr_vector;

  // Source 0 is reserved
  assign intr_vector = {intr_ext_i, uart_tx_done, 1'b0};

  assign ext_we_o    = reg_we;
  assign ext_addr_o  = reg_addr;
  assign ext_wdata_o = reg_wdata;

  periph_bus_bridge periph_bus_bridge_i (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .reg_addr_o   (reg_addr),
    .reg_we_o     (reg_we),
    .reg_wdata_o  (reg_wdata),
    .soc_valid_o  (soc_valid),
    .uart_valid_o (uart_valid),
    .intr_valid_o (intr_valid),
    .ext_valid_o,
    .soc_rdata_i  (soc_rdata),
    .uart_rdata_i (uart_rdata),
    .intr_rdata_i (intr_rdata),
    .ext_rdata_i
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_valid_i (soc_valid),
    .reg_we_i    (reg_we),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (soc_rdata),
    .exit_valid_o,
    .exit_value_o
  );

  uart_tx uart_tx_i (
    .clk_i,
    .rst_n_i,
    .reg_valid_i    (uart_valid),
    .reg_we_i       (reg_we),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_rdata_o    (uart_rdata),
    .uart_tx_o,
    .uart_tx_en_o,
    .intr_tx_done_o (uart_tx_done)
  );

  intr_ctrl intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_valid_i (intr_valid),
    .reg_we_i    (reg_we),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (intr_rdata),
    .intr_src_i  (intr_vector),
    .irq_o,
    .msip_o
  );

endmodule : peripheral_subsystem

/* hdl/intr_ctrl.sv */
/*
 * Interrupt gateway with pending, enable, claim/complete and software interrupt
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module intr_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_we_i,
  input  periph_pkg::reg_addr_t  reg_addr_i,
  input  periph_pkg::reg_data_t  reg_wdata_i,
  output periph_pkg::reg_data_t  reg_rdata_o,
  input  periph_pkg::intr_vec_t  intr_src_i,
  output logic                   irq_o,
  output logic                   msip_o
);

  periph_pkg::intr_vec_t pending_q;
  periph_pkg::intr_vec_t pending_d;
  periph_pkg::intr_vec_t in_service_q;
  periph_pkg::intr_vec_t enable_q;
  periph_pkg::intr_id_t  claim_id;
  logic                  msip_q;
  logic                  wr;
  logic                  claim_rd;

  assign wr       = reg_valid_i && reg_we_i;
  assign claim_rd = reg_valid_i && !reg_we_i && (reg_addr_i == `INTR_CLAIM_OFS);

  // Lowest pending and enabled source wins
  always_comb begin
    claim_id = '0;
    for (int i = `INTR_NUM_SRC - 1; i > 0; i--) begin
      if (pending_q[i] && enable_q[i]) claim_id = periph_pkg::intr_id_t'(i);
    end
  end

  always_comb begin
    pending_d    = pending_q | (intr_src_i & ~in_service_q);
    pending_d[0] = 1'b0;
    if (claim_rd) pending_d[claim_id] = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q    <= '0;
      in_service_q <= '0;
      enable_q     <= '0;
      msip_q       <= 1'b0;
    end else begin
      pending_q <= pending_d;
      if (claim_rd && claim_id != '0) begin
        in_service_q[claim_id] <= 1'b1;
      end
      if (wr) begin
        case (reg_addr_i)
          `INTR_ENABLE_OFS: enable_q <= reg_wdata_i[`INTR_NUM_SRC-1:0];
          `INTR_CLAIM_OFS:  in_service_q[reg_wdata_i[$bits(claim_id)-1:0]] <= 1'b0;
          `INTR_MSIP_OFS:   msip_q <= reg_wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `INTR_PENDING_OFS: reg_rdata_o[`INTR_NUM_SRC-1:0]   = pending_q;
      `INTR_ENABLE_OFS:  reg_rdata_o[`INTR_NUM_SRC-1:0]   = enable_q;
      `INTR_CLAIM_OFS:   reg_rdata_o[$bits(claim_id)-1:0] = claim_id;
      `INTR_MSIP_OFS:    reg_rdata_o[0]                   = msip_q;
      default:           reg_rdata_o                      = '0;
    endcase
  end

  assign irq_o  = |(pending_q & enable_q);
  assign msip_o = msip_q;

endmodule : intr_ctrl

/* hdl/uart_tx.sv */
/*
 * Transmit-only 8N1 UART with programmable bit divider and done interrupt
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module uart_tx (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_we_i,
  input  periph_pkg::reg_addr_t  reg_addr_i,
  input  periph_pkg::reg_data_t  reg_wdata_i,
  output periph_pkg::reg_data_t  reg_rdata_o,
  output logic                   uart_tx_o,
  output logic                   uart_tx_en_o,
  output logic                   intr_tx_done_o
);

  periph_pkg::uart_state_e state_q;
  periph_pkg::uart_div_t   div_q;
  periph_pkg::uart_div_t   bit_div_q;
  periph_pkg::uart_div_t   cnt_q;
  logic [7:0]              shift_q;
  logic [2:0]              bit_idx_q;
  logic                    done_q;
  logic                    wr;
  logic                    start;
  logic                    bit_end;

  assign wr      = reg_valid_i && reg_we_i;
  assign start   = wr && (reg_addr_i == `UART_TXDATA_OFS) && (state_q == periph_pkg::UART_IDLE);
  assign bit_end = (cnt_q == bit_div_q - 16'd1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= periph_pkg::UART_IDLE;
      div_q     <= `UART_DIV_RESET;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      done_q    <= 1'b0;
    end else begin
      if (wr && reg_addr_i == `UART_DIV_OFS) begin
        div_q <= reg_wdata_i[15:0];
      end
      if (wr && reg_addr_i == `UART_STATUS_OFS && reg_wdata_i[1]) begin
        done_q <= 1'b0;
      end
      if (state_q != periph_pkg::UART_IDLE) begin
        cnt_q <= bit_end ? '0 : cnt_q + 16'd1;
      end
      case (state_q)
        periph_pkg::UART_IDLE: begin
          cnt_q <= '0;
          if (start) state_q <= periph_pkg::UART_START;
        end
        periph_pkg::UART_START: begin
          bit_idx_q <= '0;
          if (bit_end) state_q <= periph_pkg::UART_DATA;
        end
        periph_pkg::UART_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) state_q <= periph_pkg::UART_STOP;
          end
        end
        periph_pkg::UART_STOP: begin
          if (bit_end) begin
            state_q <= periph_pkg::UART_IDLE;
            // Set wins over a same-cycle clear
            done_q  <= 1'b1;
          end
        end
        default: state_q <= periph_pkg::UART_IDLE;
      endcase
    end
  end

  // Divider is sampled at frame start, zero acts as one
  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q   <= reg_wdata_i[7:0];
      bit_div_q <= (div_q == '0) ? 16'd1 : div_q;
    end else if (state_q == periph_pkg::UART_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_comb begin
    case (state_q)
      periph_pkg::UART_START: uart_tx_o = 1'b0;
      periph_pkg::UART_DATA:  uart_tx_o = shift_q[0];
      default:                uart_tx_o = 1'b1;
    endcase
  end

  assign uart_tx_en_o   = (state_q != periph_pkg::UART_IDLE);
  assign intr_tx_done_o = done_q;

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `UART_STATUS_OFS: reg_rdata_o[1:0]  = {done_q, uart_tx_en_o};
      `UART_DIV_OFS:    reg_rdata_o[15:0] = div_q;
      default:          reg_rdata_o       = '0;
    endcase
  end

endmodule : uart_tx

/* hdl/soc_ctrl.sv */
/*
 * System control registers: exit flag, exit value and scratch word
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module soc_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_we_i,
  input  periph_pkg::reg_addr_t  reg_addr_i,
  input  periph_pkg::reg_data_t  reg_wdata_i,
  output periph_pkg::reg_data_t  reg_rdata_o,
  output logic                   exit_valid_o,
  output periph_pkg::reg_data_t  exit_value_o
);

  logic                  exit_valid_q;
  periph_pkg::reg_data_t exit_value_q;
  periph_pkg::reg_data_t scratch_q;
  logic                  wr;

  assign wr = reg_valid_i && reg_we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr) begin
      case (reg_addr_i)
        `SOC_EXIT_VALID_OFS: exit_valid_q <= reg_wdata_i[0];
        `SOC_EXIT_VALUE_OFS: exit_value_q <= reg_wdata_i;
        `SOC_SCRATCH_OFS:    scratch_q    <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `SOC_EXIT_VALID_OFS: reg_rdata_o[0] = exit_valid_q;
      `SOC_EXIT_VALUE_OFS: reg_rdata_o    = exit_value_q;
      `SOC_SCRATCH_OFS:    reg_rdata_o    = scratch_q;
      default:             reg_rdata_o    = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

/* hdl/periph_bus_bridge.sv */
/*
 * OBI to register-bus bridge: registers each request, decodes its window
 * and strobes one peripheral in the response cycle
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_bus_bridge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   req_i,
  input  logic                   we_i,
  input  obi_pkg::obi_addr_t     addr_i,
  input  obi_pkg::obi_data_t     wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output obi_pkg::obi_data_t     rdata_o,
  output logic                   err_o,

  output periph_pkg::reg_addr_t  reg_addr_o,
  output logic                   reg_we_o,
  output periph_pkg::reg_data_t  reg_wdata_o,

  output logic                   soc_valid_o,
  output logic                   uart_valid_o,
  output logic                   intr_valid_o,
  output logic                   ext_valid_o,

  input  periph_pkg::reg_data_t  soc_rdata_i,
  input  periph_pkg::reg_data_t  uart_rdata_i,
  input  periph_pkg::reg_data_t  intr_rdata_i,
  input  periph_pkg::reg_data_t  ext_rdata_i
);

  localparam int WIN_MSB = `PERIPH_SEL_LSB + 3;

  periph_pkg::periph_sel_e sel_d;
  periph_pkg::periph_sel_e sel_q;
  logic                    valid_q;
  logic                    we_q;
  periph_pkg::reg_addr_t   addr_q;
  periph_pkg::reg_data_t   wdata_q;
  periph_pkg::reg_data_t   rdata_mux;

  // Never stalls
  assign gnt_o = req_i;

  always_comb begin
    sel_d = periph_pkg::SEL_NONE;
    if (addr_i[`PERIPH_ADDR_W-1:WIN_MSB+1] == '0) begin
      case (addr_i[WIN_MSB:`PERIPH_SEL_LSB])
        `SOC_CTRL_WIN: sel_d = periph_pkg::SEL_SOC;
        `UART_WIN:     sel_d = periph_pkg::SEL_UART;
        `INTR_WIN:     sel_d = periph_pkg::SEL_INTR;
        `EXT_WIN:      sel_d = periph_pkg::SEL_EXT;
        default:       sel_d = periph_pkg::SEL_NONE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i && gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && gnt_o) begin
      sel_q   <= sel_d;
      we_q    <= we_i;
      addr_q  <= addr_i[`PERIPH_SEL_LSB-1:0];
      wdata_q <= wdata_i;
    end
  end

  assign reg_addr_o  = addr_q;
  assign reg_we_o    = we_q;
  assign reg_wdata_o = wdata_q;

  // One strobe in the response cycle
  assign soc_valid_o  = valid_q && (sel_q == periph_pkg::SEL_SOC);
  assign uart_valid_o = valid_q && (sel_q == periph_pkg::SEL_UART);
  assign intr_valid_o = valid_q && (sel_q == periph_pkg::SEL_INTR);
  assign ext_valid_o  = valid_q && (sel_q == periph_pkg::SEL_EXT);

  always_comb begin
    case (sel_q)
      periph_pkg::SEL_SOC:  rdata_mux = soc_rdata_i;
      periph_pkg::SEL_UART: rdata_mux = uart_rdata_i;
      periph_pkg::SEL_INTR: rdata_mux = intr_rdata_i;
      periph_pkg::SEL_EXT:  rdata_mux = ext_rdata_i;
      default:              rdata_mux = '0;
    endcase
  end

  assign rvalid_o = valid_q;
  assign rdata_o  = we_q ? '0 : rdata_mux;
  assign err_o    = valid_q && (sel_q == periph_pkg::SEL_NONE);

endmodule : periph_bus_bridge

/* hdl/periph_pkg.sv */
/*
 * Register-bus types, peripheral select and FSM state encodings
 */
`include "periph_consts.svh"

package periph_pkg;

  typedef logic [`PERIPH_SEL_LSB-1:0] reg_addr_t;
  typedef logic [`PERIPH_DATA_W-1:0] reg_data_t;

  typedef logic [`INTR_NUM_SRC-1:0] intr_vec_t;
  typedef logic [$clog2(`INTR_NUM_SRC)-1:0] intr_id_t;

  typedef logic [15:0] uart_div_t;

  typedef enum logic [2:0] {
    SEL_SOC,
    SEL_UART,
    SEL_INTR,
    SEL_EXT,
    SEL_NONE
  } periph_sel_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage : periph_pkg

/* hdl/obi_pkg.sv */
/*
 * OBI core-side bus types
 */
`include "periph_consts.svh"

package obi_pkg;

  // Core address and data words
  typedef logic [`PERIPH_ADDR_W-1:0] obi_addr_t;
  typedef logic [`PERIPH_DATA_W-1:0] obi_data_t;

endpackage : obi_pkg

/* include/periph_consts.svh */
/*
 * Peripheral subsystem constants: address windows, register offsets and sizes
 */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_SEL_LSB 12

// Window numbers in address bits 15:12
`define SOC_CTRL_WIN 4'd0
`define UART_WIN 4'd1
`define INTR_WIN 4'd2
`define EXT_WIN 4'd3

`define SOC_EXIT_VALID_OFS 12'h000
`define SOC_EXIT_VALUE_OFS 12'h004
`define SOC_SCRATCH_OFS 12'h008

`define UART_TXDATA_OFS 12'h000
`define UART_STATUS_OFS 12'h004
`define UART_DIV_OFS 12'h008
`define UART_DIV_RESET 16'd4

`define INTR_PENDING_OFS 12'h000
`define INTR_ENABLE_OFS 12'h004
`define INTR_CLAIM_OFS 12'h008
`define INTR_MSIP_OFS 12'h00C
`define INTR_NUM_SRC 8

`define EXT_NINTR 6

`endif
